// File: sniffer_defs.svh
// ----------------------------
// Packet sniffer parameters
// Data width, capture buffer size and
// control register indices
// ----------------------------
`ifndef SNIFFER_DEFS_SVH
`define SNIFFER_DEFS_SVH

// Beat, buffer word and control data width
`define SNF_DATA_BITS 64
// Control byte address width
`define SNF_AXIL_ADDR_BITS 6

// Capture buffer geometry
`define SNF_BUF_DEPTH 256
`define SNF_BUF_ADDR_BITS 8

// Register indices, 8 bytes apart
`define SNF_REG_CTRL 0
`define SNF_REG_FILTER 1
`define SNF_REG_LEN 2
`define SNF_REG_STATE 3
`define SNF_REG_SIZE 4
`define SNF_REG_TIMER 5

`endif

// File: sniffer_pkg.sv
// ----------------------------
// Packet sniffer types
// Width typedefs, capture state and the
// bundles passed between blocks
// ----------------------------
`default_nettype none
`include "sniffer_defs.svh"

package sniffer_pkg;

  // Widths with a meaning
  typedef logic [`SNF_DATA_BITS-1:0] snf_data_t;
  typedef logic [`SNF_BUF_ADDR_BITS-1:0] snf_addr_t;
  // One extra bit so a full buffer is representable
  typedef logic [`SNF_BUF_ADDR_BITS:0] snf_count_t;
  typedef logic [5:0] snf_class_t;
  typedef logic [63:0] snf_timer_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ARMED   = 2'd1,
    CAPTURE = 2'd2,
    FULL    = 2'd3
  } snf_state_e;

  // ----------------------------
  // AXI-Lite control channels
  // ----------------------------
  typedef struct packed {
    logic                           awvalid;
    logic [`SNF_AXIL_ADDR_BITS-1:0] awaddr;
    logic                           wvalid;
    snf_data_t                      wdata;
    logic [`SNF_DATA_BITS/8-1:0]    wstrb;
    logic                           bready;
    logic                           arvalid;
    logic [`SNF_AXIL_ADDR_BITS-1:0] araddr;
    logic                           rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    snf_data_t  rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  // ----------------------------
  // Data path bundles
  // ----------------------------
  typedef struct packed {
    logic      valid;
    snf_data_t data;
    logic      last;
  } tap_beat_t;

  typedef struct packed {
    snf_data_t data;
    logic      last;
  } buf_word_t;

  typedef struct packed {
    logic      valid;
    snf_addr_t addr;
    buf_word_t word;
  } buf_wr_t;

  typedef struct packed {
    logic      valid;
    snf_addr_t addr;
  } buf_rd_t;

  // Valid and ready travel beside it
  typedef struct packed {
    snf_data_t data;
    logic      last;
  } drain_beat_t;

endpackage

`default_nettype wire

// File: sniffer_csr.sv
// ----------------------------
// Sniffer control slave
// AXI-Lite register file: enable, filter
// mask and length limit, plus live status
// reads of state, size and timer
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sniffer_defs.svh"

module sniffer_csr
  import sniffer_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  output logic       cap_enable,
  output snf_data_t  cap_filter,
  output snf_count_t cap_len,
  input  snf_state_e cap_state,
  input  snf_count_t cap_size,
  input  snf_timer_t cap_timer
);

  localparam int NB = `SNF_DATA_BITS / 8;
  localparam int ADDR_LSB = $clog2(NB);
  localparam int IDX_BITS = `SNF_AXIL_ADDR_BITS - ADDR_LSB;

  // Channel state
  logic [`SNF_AXIL_ADDR_BITS-1:0] awaddr_q;
  logic [`SNF_AXIL_ADDR_BITS-1:0] araddr_q;
  logic awready_q;
  logic wready_q;
  logic bvalid_q;
  logic arready_q;
  logic rvalid_q;
  logic aw_en_q;
  snf_data_t rdata_q;

  // Register file
  logic ctrl_q;
  snf_data_t filter_q;
  snf_count_t len_q;

  logic reg_wren;
  logic reg_rden;
  logic [IDX_BITS-1:0] wr_idx;
  logic [IDX_BITS-1:0] rd_idx;
  snf_data_t wr_cur;
  snf_data_t wr_merged;
  snf_data_t rd_value;

  // Overlay strobed bytes of wdata on the current value
  function automatic snf_data_t merge_bytes(
    input snf_data_t        cur,
    input snf_data_t        wdata,
    input logic [NB-1:0]    strb
  );
    snf_data_t res;
    res = cur;
    for (int i = 0; i < NB; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------
  // Register writes
  // ----------------------------
  assign reg_wren = wready_q && axil_req.wvalid && awready_q && axil_req.awvalid;
  assign wr_idx = awaddr_q[ADDR_LSB +: IDX_BITS];

  // Current value of the addressed register, zero-extended
  always_comb begin
    case (wr_idx)
      `SNF_REG_CTRL:   wr_cur = snf_data_t'(ctrl_q);
      `SNF_REG_FILTER: wr_cur = filter_q;
      `SNF_REG_LEN:    wr_cur = snf_data_t'(len_q);
      default:         wr_cur = '0;
    endcase
    wr_merged = merge_bytes(wr_cur, axil_req.wdata, axil_req.wstrb);
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ctrl_q   <= 1'b0;
      filter_q <= '0;
      len_q    <= '0;
    end else if (reg_wren) begin
      // Status registers and holes drop the write
      case (wr_idx)
        `SNF_REG_CTRL:   ctrl_q <= wr_merged[0];
        `SNF_REG_FILTER: filter_q <= wr_merged;
        `SNF_REG_LEN:    len_q <= wr_merged[`SNF_BUF_ADDR_BITS:0];
        default: ;
      endcase
    end
  end

  // ----------------------------
  // Register reads
  // ----------------------------
  assign reg_rden = arready_q && axil_req.arvalid && !rvalid_q;
  assign rd_idx = araddr_q[ADDR_LSB +: IDX_BITS];

  // Status sampled live at the read
  always_comb begin
    case (rd_idx)
      `SNF_REG_CTRL:   rd_value = snf_data_t'(ctrl_q);
      `SNF_REG_FILTER: rd_value = filter_q;
      `SNF_REG_LEN:    rd_value = snf_data_t'(len_q);
      `SNF_REG_STATE:  rd_value = snf_data_t'(cap_state);
      `SNF_REG_SIZE:   rd_value = snf_data_t'(cap_size);
      `SNF_REG_TIMER:  rd_value = snf_data_t'(cap_timer);
      default:         rd_value = '0;
    endcase
  end

  // ----------------------------
  // Channel handshakes
  // ----------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      aw_en_q   <= 1'b1;
      bvalid_q  <= 1'b0;
    end else begin
      // Address and data accepted together, one write at a time
      if (!awready_q && axil_req.awvalid && axil_req.wvalid && aw_en_q) begin
        awready_q <= 1'b1;
        wready_q  <= 1'b1;
        aw_en_q   <= 1'b0;
        awaddr_q  <= axil_req.awaddr;
      end else begin
        awready_q <= 1'b0;
        wready_q  <= 1'b0;
        if (axil_req.bready && bvalid_q) begin
          aw_en_q <= 1'b1;
        end
      end
      // Response held until bready
      if (reg_wren && !bvalid_q) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready && bvalid_q) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
    end else begin
      // No new read while a response waits
      if (!arready_q && axil_req.arvalid && !rvalid_q) begin
        arready_q <= 1'b1;
        araddr_q  <= axil_req.araddr;
      end else begin
        arready_q <= 1'b0;
      end
      if (reg_rden) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_value;
      end else if (rvalid_q && axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Responses are always OKAY
  always_comb begin
    axil_rsp.awready = awready_q;
    axil_rsp.wready  = wready_q;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = 2'b00;
    axil_rsp.arready = arready_q;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = 2'b00;
  end

  assign cap_enable = ctrl_q;
  assign cap_filter = filter_q;
  assign cap_len    = len_q;

endmodule

`default_nettype wire

// File: sniffer_capture.sv
// ----------------------------
// Sniffer capture engine
// Filters tap packets by class, writes
// accepted beats to the buffer and keeps
// size, state and a free-running timer
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sniffer_defs.svh"

module sniffer_capture
  import sniffer_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       enable,
  input  snf_data_t  filter,
  input  snf_count_t len,
  input  tap_beat_t  tap,
  output buf_wr_t    buf_wr,
  output snf_count_t wr_count,
  output logic       session_start,
  output snf_state_e state,
  output snf_timer_t timer
);

  localparam snf_count_t DEPTH = snf_count_t'(`SNF_BUF_DEPTH);

  snf_state_e state_q;
  logic enable_q;
  logic in_pkt_q;
  logic start_q;
  snf_count_t wr_ptr_q;
  snf_count_t count_q;
  snf_timer_t timer_q;
  buf_wr_t wr_q;

  snf_class_t pkt_class;
  snf_count_t limit;
  snf_count_t ptr_next;
  logic rise;
  logic room;
  logic take;

  assign rise = enable && !enable_q;
  assign pkt_class = tap.data[5:0];
  // Length limit never exceeds the buffer
  assign limit = (len > DEPTH) ? DEPTH : len;
  assign room = wr_ptr_q < limit;
  assign ptr_next = wr_ptr_q + 1'b1;

  // Filter decision
  always_comb begin
    case (state_q)
      // Only the first beat of a packet may open a capture
      ARMED:   take = tap.valid && !in_pkt_q && filter[pkt_class] && room;
      CAPTURE: take = tap.valid && room;
      default: take = 1'b0;
    endcase
    if (!enable || rise) begin
      take = 1'b0;
    end
  end

  // ----------------------------
  // Capture FSM
  // ----------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q  <= IDLE;
      enable_q <= 1'b0;
      in_pkt_q <= 1'b0;
      start_q  <= 1'b0;
      wr_ptr_q <= '0;
    end else begin
      enable_q <= enable;
      start_q  <= rise;
      // Packet boundary tracking, independent of state
      if (tap.valid) begin
        in_pkt_q <= !tap.last;
      end
      if (!enable) begin
        state_q <= IDLE;
      end else if (rise) begin
        state_q  <= ARMED;
        wr_ptr_q <= '0;
      end else begin
        if (take) begin
          wr_ptr_q <= ptr_next;
        end
        case (state_q)
          ARMED: begin
            if (!room) begin
              state_q <= FULL;
            end else if (take) begin
              if (ptr_next >= limit) begin
                state_q <= FULL;
              end else if (!tap.last) begin
                state_q <= CAPTURE;
              end
            end
          end
          CAPTURE: begin
            // Reaching the limit truncates the packet
            if (!room) begin
              state_q <= FULL;
            end else if (take) begin
              if (ptr_next >= limit) begin
                state_q <= FULL;
              end else if (tap.last) begin
                state_q <= ARMED;
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Buffer write one edge after the tap beat
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_q.valid <= 1'b0;
    end else begin
      wr_q.valid <= take;
    end
    if (take) begin
      wr_q.addr      <= snf_addr_t'(wr_ptr_q);
      wr_q.word.data <= tap.data;
      wr_q.word.last <= tap.last;
    end
  end

  // Size follows the buffer write itself
  always_ff @(posedge aclk) begin
    if (!aresetn || rise) begin
      count_q <= '0;
    end else if (wr_q.valid) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

  assign buf_wr        = wr_q;
  assign wr_count      = count_q;
  assign session_start = start_q;
  assign state         = state_q;
  assign timer         = timer_q;

endmodule

`default_nettype wire

// File: sniffer_buf_arb.sv
// ----------------------------
// Capture buffer arbiter
// Single-port RAM shared by capture and
// drain, capture writes always win
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sniffer_defs.svh"

module sniffer_buf_arb
  import sniffer_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  input  buf_wr_t   wr,
  input  buf_rd_t   rd,
  output logic      rd_grant,
  output buf_word_t rd_word
);

  // Capture storage
  buf_word_t mem [`SNF_BUF_DEPTH];
  buf_word_t rd_q;

  // ----------------------------
  // Port arbitration
  // ----------------------------
  // The tap cannot stall, so a read only
  // gets the port on an idle write cycle
  assign rd_grant = rd.valid && !wr.valid;

  always_ff @(posedge aclk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.word;
    end
  end

  // Read data register, one cycle after grant
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_q <= '0;
    end else if (rd_grant) begin
      rd_q <= mem[rd.addr];
    end
  end

  assign rd_word = rd_q;

endmodule

`default_nettype wire

// File: sniffer_drain.sv
// ----------------------------
// Sniffer drain engine
// Fetches captured words in order and
// streams them out under valid/ready
// through a two-entry skid buffer
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sniffer_defs.svh"

module sniffer_drain
  import sniffer_pkg::*;
(
  input  logic        aclk,
  input  logic        aresetn,
  input  logic        session_start,
  input  snf_count_t  wr_count,
  output buf_rd_t     rd,
  input  logic        rd_grant,
  input  buf_word_t   rd_word,
  output logic        out_valid,
  input  logic        out_ready,
  output drain_beat_t out_beat
);

  // Skid storage and pointers
  drain_beat_t skid_mem [2];
  logic skid_wr_q;
  logic skid_rd_q;
  logic [1:0] skid_cnt_q;

  // Word fetched last cycle, arriving now
  logic inflight_q;
  snf_count_t rd_ptr_q;

  logic room;
  logic push;
  logic pop;

  // Stored words plus the one in flight must fit in two entries
  assign room = (skid_cnt_q == 2'd0) || ((skid_cnt_q == 2'd1) && !inflight_q);
  assign push = inflight_q;
  assign pop  = out_valid && out_ready;

  always_comb begin
    rd.valid = (rd_ptr_q < wr_count) && room;
    rd.addr  = snf_addr_t'(rd_ptr_q);
  end

  // ----------------------------
  // Fetch and skid control
  // ----------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn || session_start) begin
      // New session restarts from word 0, old words dropped
      rd_ptr_q   <= '0;
      inflight_q <= 1'b0;
      skid_wr_q  <= 1'b0;
      skid_rd_q  <= 1'b0;
      skid_cnt_q <= 2'd0;
    end else begin
      inflight_q <= rd_grant;
      if (rd_grant) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push) begin
        skid_wr_q <= !skid_wr_q;
      end
      if (pop) begin
        skid_rd_q <= !skid_rd_q;
      end
      skid_cnt_q <= skid_cnt_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      skid_mem[skid_wr_q].data <= rd_word.data;
      skid_mem[skid_wr_q].last <= rd_word.last;
    end
  end

  // Head entry stays put until taken
  assign out_valid = skid_cnt_q != 2'd0;
  assign out_beat  = skid_mem[skid_rd_q];

endmodule

`default_nettype wire

// File: packet_sniffer_top.sv
// ----------------------------
// Packet sniffer top level
// Control slave, capture engine, buffer
// arbiter and drain engine
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sniffer_defs.svh"

module packet_sniffer_top
  import sniffer_pkg::*;
(
  input  logic        aclk,
  input  logic        aresetn,
  input  axil_req_t   axil_req,
  output axil_rsp_t   axil_rsp,
  input  tap_beat_t   tap,
  output logic        out_valid,
  input  logic        out_ready,
  output drain_beat_t out_beat
);

  // Control to capture
  logic       cap_enable;
  snf_data_t  cap_filter;
  snf_count_t cap_len;
  // Capture status
  snf_state_e cap_state;
  snf_count_t wr_count;
  snf_timer_t cap_timer;
  logic       session_start;
  // Buffer ports
  buf_wr_t    buf_wr;
  buf_rd_t    buf_rd;
  logic       rd_grant;
  buf_word_t  rd_word;

  sniffer_csr u_csr (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .cap_enable (cap_enable),
    .cap_filter (cap_filter),
    .cap_len    (cap_len),
    .cap_state  (cap_state),
    .cap_size   (wr_count),
    .cap_timer  (cap_timer)
  );

  sniffer_capture u_capture (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .enable        (cap_enable),
    .filter        (cap_filter),
    .len           (cap_len),
    .tap           (tap),
    .buf_wr        (buf_wr),
    .wr_count      (wr_count),
    .session_start (session_start),
    .state         (cap_state),
    .timer         (cap_timer)
  );

  sniffer_buf_arb u_buf_arb (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr       (buf_wr),
    .rd       (buf_rd),
    .rd_grant (rd_grant),
    .rd_word  (rd_word)
  );

  sniffer_drain u_drain (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .session_start (session_start),
    .wr_count      (wr_count),
    .rd            (buf_rd),
    .rd_grant      (rd_grant),
    .rd_word       (rd_word),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_beat      (out_beat)
  );

endmodule

`default_nettype wire

// File: tb_packet_sniffer.sv
// ----------------------------
// Packet sniffer testbench
// Replays the stim file against the DUT,
// models the filter and length rules and
// checks drain output and registers
// ----------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sniffer_defs.svh"

module tb_packet_sniffer
  import sniffer_pkg::*;
();

  localparam int WAIT_LIMIT = 4000;
  localparam int CLK_HALF = 2;

  logic        aclk;
  logic        aresetn;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  tap_beat_t   tap;
  logic        out_valid;
  logic        out_ready;
  drain_beat_t out_beat;

  // Reference model state
  buf_word_t   exp_q[$];
  logic        m_enable;
  snf_data_t   m_filter;
  snf_count_t  m_len;
  snf_count_t  m_count;
  logic [57:0] seq;
  snf_data_t   last_timer;
  logic        have_timer;

  packet_sniffer_top DUT (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .tap       (tap),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  initial begin
    aclk = 1'b0;
    forever begin
      #CLK_HALF aclk = ~aclk;
    end
  end

  // Drive and sample 1 ns past the edge
  task automatic tick();
    @(posedge aclk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string msg);
    $display("ERR %0d ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "value mismatch");
  endtask

  // ----------------------------
  // Compare tasks
  // ----------------------------
  task automatic check_reg(input string what, input snf_data_t got, input snf_data_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s read 0x%h, expected 0x%h", what, got, exp));
    end
  endtask

  task automatic check_beat(input drain_beat_t got, input drain_beat_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("drain beat 0x%h last %0b, expected 0x%h last %0b",
                                got.data, got.last, exp.data, exp.last));
    end
  endtask

  task automatic check_state(input snf_state_e got, input snf_state_e exp);
    if (got !== exp) begin
      report_mismatch($sformatf("STATE read %s, expected %s", got.name(), exp.name()));
    end
  endtask

  // Only OKAY is ever returned
  task automatic check_resp(input string what, input logic [1:0] got);
    if (got !== 2'b00) begin
      report_mismatch($sformatf("%s response %0b, expected OKAY", what, got));
    end
  endtask

  // ----------------------------
  // AXI-Lite master
  // ----------------------------
  task automatic axil_write(input logic [5:0] addr, input snf_data_t data,
                            input logic [7:0] strb);
    int n;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.bready  = 1'b1;
    n = 0;
    do begin
      tick();
      n++;
      if (n > WAIT_LIMIT) abort_run("timeout waiting for awready and wready");
    end while (!(axil_rsp.awready && axil_rsp.wready));
    // Handshake completes on the following edge
    tick();
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    while (!axil_rsp.bvalid) begin
      tick();
      n++;
      if (n > WAIT_LIMIT) abort_run("timeout waiting for bvalid");
    end
    check_resp("write", axil_rsp.bresp);
    tick();
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [5:0] addr, output snf_data_t data);
    int n;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    n = 0;
    do begin
      tick();
      n++;
      if (n > WAIT_LIMIT) abort_run("timeout waiting for arready");
    end while (!axil_rsp.arready);
    tick();
    axil_req.arvalid = 1'b0;
    n = 0;
    while (!axil_rsp.rvalid) begin
      tick();
      n++;
      if (n > WAIT_LIMIT) abort_run("timeout waiting for rvalid");
    end
    data = axil_rsp.rdata;
    check_resp("read", axil_rsp.rresp);
    tick();
    axil_req.rready = 1'b0;
  endtask

  // ----------------------------
  // Reference model
  // ----------------------------
  function automatic snf_data_t apply_strobes(input snf_data_t cur, input snf_data_t data,
                                              input logic [7:0] strb);
    snf_data_t res;
    res = cur;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  task automatic model_write(input logic [5:0] addr, input snf_data_t data,
                             input logic [7:0] strb);
    snf_data_t v;
    case (addr[5:3])
      `SNF_REG_CTRL: begin
        v = apply_strobes(snf_data_t'(m_enable), data, strb);
        // New session on a rising enable
        if (v[0] && !m_enable) m_count = '0;
        m_enable = v[0];
      end
      `SNF_REG_FILTER: m_filter = apply_strobes(m_filter, data, strb);
      `SNF_REG_LEN: begin
        v = apply_strobes(snf_data_t'(m_len), data, strb);
        m_len = v[`SNF_BUF_ADDR_BITS:0];
      end
      default: ;
    endcase
  endtask

  // One packet on the tap at one beat per cycle
  task automatic drive_packet(input snf_class_t cls, input int nbeats);
    logic       take_pkt;
    buf_word_t  w;
    snf_count_t limit;
    limit = (m_len > `SNF_BUF_DEPTH) ? snf_count_t'(`SNF_BUF_DEPTH) : m_len;
    // Filter decided on the first beat only
    take_pkt = m_enable && m_filter[cls];
    for (int i = 0; i < nbeats; i++) begin
      w.data = {seq, cls};
      w.last = (i == nbeats - 1);
      seq++;
      // Past the limit the rest is truncated
      if (take_pkt && m_count < limit) begin
        exp_q.push_back(w);
        m_count++;
      end
      tap.valid = 1'b1;
      tap.data  = w.data;
      tap.last  = w.last;
      tick();
    end
    tap.valid = 1'b0;
    tap.last  = 1'b0;
  endtask

  task automatic run_read(input logic [5:0] addr, input snf_data_t exp);
    snf_data_t got;
    axil_read(addr, got);
    case (addr[5:3])
      `SNF_REG_STATE: check_state(snf_state_e'(got[1:0]), snf_state_e'(exp[1:0]));
      `SNF_REG_SIZE: begin
        check_reg("SIZE", got, exp);
        check_reg("SIZE against model", got, snf_data_t'(m_count));
      end
      default: check_reg($sformatf("register 0x%h", addr), got, exp);
    endcase
  endtask

  task automatic sample_timer();
    snf_data_t t;
    axil_read(6'(`SNF_REG_TIMER * 8), t);
    if (have_timer && !(t > last_timer)) begin
      report_mismatch($sformatf("TIMER read 0x%h, not above 0x%h", t, last_timer));
    end
    last_timer = t;
    have_timer = 1'b1;
  endtask

  task automatic wait_drain_empty();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      tick();
      n++;
      if (n > WAIT_LIMIT) abort_run("timeout waiting for the drain to deliver all words");
    end
    tick();
    if (out_valid) abort_run("drain holds a word that was never captured");
  endtask

  // ----------------------------
  // Drain monitor
  // ----------------------------
  initial begin
    int unsigned seed;
    buf_word_t w;
    seed = 32'h6dfd_1557;
    out_ready = 1'b0;
    void'($urandom(seed));
    forever begin
      tick();
      // Random back-pressure on about half the cycles
      out_ready = (($urandom % 2) == 1);
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) abort_run("drain delivered a word that was never captured");
        w = exp_q.pop_front();
        check_beat(out_beat, drain_beat_t'(w));
      end
    end
  end

  // ----------------------------
  // Stimulus
  // ----------------------------
  initial begin
    int fd;
    string line;
    logic [7:0] cmd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    aresetn    = 1'b0;
    axil_req   = '0;
    tap        = '0;
    m_enable   = 1'b0;
    m_filter   = '0;
    m_len      = '0;
    m_count    = '0;
    seq        = '0;
    last_timer = '0;
    have_timer = 1'b0;
    repeat (5) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    tick();
    fd = $fopen("sniffer_stim.txt", "r");
    if (fd == 0) abort_run("cannot open sniffer_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Blank lines and comments
      if (line.len() < 2 || line[0] == "#") continue;
      a = '0;
      b = '0;
      c = '0;
      void'($sscanf(line, "%c %h %h %h", cmd, a, b, c));
      case (cmd)
        "W": begin
          model_write(a[5:0], b, c[7:0]);
          axil_write(a[5:0], b, c[7:0]);
        end
        "R": run_read(a[5:0], b);
        "P": drive_packet(snf_class_t'(a[5:0]), int'(b));
        "E": wait_drain_empty();
        "T": sample_timer();
        default: abort_run({"unknown stim command: ", line});
      endcase
    end
    $fclose(fd);
    wait_drain_empty();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sniffer_stim.txt
# W addr data strb | R addr expected | P class beats | E drain empty | T timer sample
# Hex fields; registers at 00 CTRL, 08 FILTER, 10 LEN, 18 STATE, 20 SIZE, 28 TIMER
R 18 0
R 20 0
W 08 00000000000000ff ff
W 08 a5a5a5a5a5a5a5a5 0c
R 08 00000000a5a500ff
W 10 0000000000001f40 01
R 10 40
W 00 1 01
R 00 1
R 18 1
P 03 4
P 09 3
P 10 5
P 11 2
P 02 1
E
R 20 0a
P 05 6
P 1f 3
P 28 4
P 07 8
E
R 20 1b
T
T
W 00 0 01
R 18 0
W 10 7 01
R 10 7
W 00 1 01
P 03 3
P 09 2
P 04 6
P 05 2
E
R 20 7
R 18 3

// File: tb.f
+incdir+.
sniffer_pkg.sv
sniffer_csr.sv
sniffer_capture.sv
sniffer_buf_arb.sv
sniffer_drain.sv
packet_sniffer_top.sv
tb_packet_sniffer.sv

// File: Bender.yml
package:
  name: packet_sniffer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sniffer_pkg.sv
      - sniffer_csr.sv
      - sniffer_capture.sv
      - sniffer_buf_arb.sv
      - sniffer_drain.sv
      - packet_sniffer_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_packet_sniffer.sv
